// ==== sources.f ====
+incdir+testbench
src/uart_axi_pkg.sv
src/uart_regs_pkg.sv
src/byte_fifo.sv
src/axi_lite_slave.sv
src/uart_reg_file.sv
src/uart_axi_top.sv
testbench/uart_axi_props.sv
testbench/uart_axi_tb.sv

// ==== src/axi_lite_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_lite_slave (
	input  wire                                    s_axi_aclk_i,
	input  wire                                    s_axi_aresetn_i,
	// write address / data / response
	input  wire [uart_axi_pkg::ADDR_W-1:0]         s_axi_awaddr_i,
	input  wire                                    s_axi_awvalid_i,
	output logic                                   s_axi_awready_o,
	input  wire [uart_axi_pkg::DATA_W-1:0]         s_axi_wdata_i,
	input  wire [uart_axi_pkg::STRB_W-1:0]         s_axi_wstrb_i,
	input  wire                                    s_axi_wvalid_i,
	output logic                                   s_axi_wready_o,
	output logic [1:0]                             s_axi_bresp_o,
	output logic                                   s_axi_bvalid_o,
	input  wire                                    s_axi_bready_i,
	// read address / data
	input  wire [uart_axi_pkg::ADDR_W-1:0]         s_axi_araddr_i,
	input  wire                                    s_axi_arvalid_i,
	output logic                                   s_axi_arready_o,
	output logic [uart_axi_pkg::DATA_W-1:0]        s_axi_rdata_o,
	output logic [1:0]                             s_axi_rresp_o,
	output logic                                   s_axi_rvalid_o,
	input  wire                                    s_axi_rready_i,
	// register file side
	output logic                                   wr_req_o,
	output logic [uart_regs_pkg::REG_OFS_W-1:0]    wr_ofs_o,
	output logic [uart_axi_pkg::DATA_W-1:0]        wr_data_o,
	output logic [uart_axi_pkg::STRB_W-1:0]        wr_strb_o,
	input  wire                                    wr_err_i,
	output logic                                   rd_req_o,
	output logic [uart_regs_pkg::REG_OFS_W-1:0]    rd_ofs_o,
	input  wire [uart_axi_pkg::DATA_W-1:0]         rd_data_i,
	input  wire                                    rd_err_i
);

	logic wr_acc;
	logic rd_acc;
	logic wr_hit;
	logic rd_hit;

	// upper address bits must match the base
	assign wr_hit = (s_axi_awaddr_i & ~uart_axi_pkg::UART_ADDR_MASK) ==
		uart_axi_pkg::UART_BASE_ADDR;
	assign rd_hit = (s_axi_araddr_i & ~uart_axi_pkg::UART_ADDR_MASK) ==
		uart_axi_pkg::UART_BASE_ADDR;

	// aw and w are taken together, one write outstanding
	assign wr_acc          = s_axi_awvalid_i && s_axi_wvalid_i && !s_axi_bvalid_o;
	assign s_axi_awready_o = wr_acc;
	assign s_axi_wready_o  = wr_acc;

	assign rd_acc          = s_axi_arvalid_i && !s_axi_rvalid_o;
	assign s_axi_arready_o = rd_acc;

	assign wr_req_o  = wr_acc && wr_hit;  // no request on a base miss
	assign wr_ofs_o  = s_axi_awaddr_i[uart_regs_pkg::REG_OFS_W-1:0];
	assign wr_data_o = s_axi_wdata_i;
	assign wr_strb_o = s_axi_wstrb_i;

	assign rd_req_o = rd_acc && rd_hit;
	assign rd_ofs_o = s_axi_araddr_i[uart_regs_pkg::REG_OFS_W-1:0];

	always_ff @(posedge s_axi_aclk_i) begin
		if (!s_axi_aresetn_i) begin
			s_axi_bvalid_o <= 1'b0;
		end else if (wr_acc) begin
			s_axi_bvalid_o <= 1'b1;
		end else if (s_axi_bready_i) begin
			s_axi_bvalid_o <= 1'b0;  // response taken
		end
	end

	always_ff @(posedge s_axi_aclk_i) begin
		if (!s_axi_aresetn_i) begin
			s_axi_rvalid_o <= 1'b0;
		end else if (rd_acc) begin
			s_axi_rvalid_o <= 1'b1;
		end else if (s_axi_rready_i) begin
			s_axi_rvalid_o <= 1'b0;
		end
	end

	// response payload, loaded on accept and held until taken
	always_ff @(posedge s_axi_aclk_i) begin
		if (wr_acc) begin
			s_axi_bresp_o <= (wr_hit && !wr_err_i) ? uart_axi_pkg::RESP_OKAY :
				uart_axi_pkg::RESP_SLVERR;
		end
		if (rd_acc) begin
			if (rd_hit && !rd_err_i) begin
				s_axi_rdata_o <= rd_data_i;
				s_axi_rresp_o <= uart_axi_pkg::RESP_OKAY;
			end else begin
				s_axi_rdata_o <= '0;  // error reads return zero
				s_axi_rresp_o <= uart_axi_pkg::RESP_SLVERR;
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/byte_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_fifo #(
	parameter int DEPTH = uart_regs_pkg::FIFO_DEPTH
) (
	input  wire                              s_axi_aclk_i,
	input  wire                              s_axi_aresetn_i,
	input  wire                              push_i,
	input  wire [uart_regs_pkg::BYTE_W-1:0]  push_data_i,
	input  wire                              pop_i,
	output logic [uart_regs_pkg::BYTE_W-1:0] pop_data_o,
	output logic                             empty_o,
	output logic                             full_o
);

	localparam int IDX_W = $clog2(DEPTH);

	logic [uart_regs_pkg::BYTE_W-1:0] mem [DEPTH];
	logic [IDX_W:0] wr_ptr;  // extra msb tells full from empty
	logic [IDX_W:0] rd_ptr;
	logic do_push;
	logic do_pop;

	assign empty_o = (wr_ptr == rd_ptr);
	assign full_o  = (wr_ptr[IDX_W] != rd_ptr[IDX_W]) &&
		(wr_ptr[IDX_W-1:0] == rd_ptr[IDX_W-1:0]);

	// illegal requests are dropped here
	assign do_push = push_i && !full_o;
	assign do_pop  = pop_i && !empty_o;

	assign pop_data_o = mem[rd_ptr[IDX_W-1:0]];  // head, fall-through

	always_ff @(posedge s_axi_aclk_i) begin
		if (do_push) begin
			mem[wr_ptr[IDX_W-1:0]] <= push_data_i;
		end
	end

	always_ff @(posedge s_axi_aclk_i) begin
		if (!s_axi_aresetn_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/uart_axi_pkg.sv ====
`default_nettype none

package uart_axi_pkg;

	// bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;  // one strobe per byte lane

	// peripheral window
	localparam logic [ADDR_W-1:0] UART_BASE_ADDR = 32'h2000_0000;
	localparam logic [ADDR_W-1:0] UART_ADDR_MASK = 32'h0000_000F;  // register select bits

	// response codes on bresp / rresp
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

// ==== src/uart_axi_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_axi_top (
	input  wire                              s_axi_aclk_i,
	input  wire                              s_axi_aresetn_i,
	input  wire [uart_axi_pkg::ADDR_W-1:0]   s_axi_awaddr_i,
	input  wire                              s_axi_awvalid_i,
	output logic                             s_axi_awready_o,
	input  wire [uart_axi_pkg::DATA_W-1:0]   s_axi_wdata_i,
	input  wire [uart_axi_pkg::STRB_W-1:0]   s_axi_wstrb_i,
	input  wire                              s_axi_wvalid_i,
	output logic                             s_axi_wready_o,
	output logic [1:0]                       s_axi_bresp_o,
	output logic                             s_axi_bvalid_o,
	input  wire                              s_axi_bready_i,
	input  wire [uart_axi_pkg::ADDR_W-1:0]   s_axi_araddr_i,
	input  wire                              s_axi_arvalid_i,
	output logic                             s_axi_arready_o,
	output logic [uart_axi_pkg::DATA_W-1:0]  s_axi_rdata_o,
	output logic [1:0]                       s_axi_rresp_o,
	output logic                             s_axi_rvalid_o,
	input  wire                              s_axi_rready_i,
	// uart byte bus
	output logic [uart_regs_pkg::BYTE_W-1:0] tx_o,
	output logic                             tx_en_o,
	input  wire                              t_done_i,
	input  wire [uart_regs_pkg::BYTE_W-1:0]  rx_i,
	output logic                             rx_en_o,
	input  wire                              r_done_i,
	output logic [uart_regs_pkg::BAUD_W-1:0] baud_div_o
);

	logic                                 wr_req;
	logic [uart_regs_pkg::REG_OFS_W-1:0]  wr_ofs;
	logic [uart_axi_pkg::DATA_W-1:0]      wr_data;
	logic [uart_axi_pkg::STRB_W-1:0]      wr_strb;
	logic                                 wr_err;
	logic                                 rd_req;
	logic [uart_regs_pkg::REG_OFS_W-1:0]  rd_ofs;
	logic [uart_axi_pkg::DATA_W-1:0]      rd_data;
	logic                                 rd_err;
	logic                                 tx_push;
	logic [uart_regs_pkg::BYTE_W-1:0]     tx_push_data;
	logic                                 tx_pop;
	logic                                 tx_empty;
	logic                                 tx_full;
	logic                                 rx_push;
	logic                                 rx_pop;
	logic [uart_regs_pkg::BYTE_W-1:0]     rx_head;
	logic                                 rx_empty;
	logic                                 rx_full;

	axi_lite_slave axi_lite_slave_inst (
		.s_axi_aclk_i, .s_axi_aresetn_i,
		.s_axi_awaddr_i, .s_axi_awvalid_i, .s_axi_awready_o,
		.s_axi_wdata_i, .s_axi_wstrb_i, .s_axi_wvalid_i, .s_axi_wready_o,
		.s_axi_bresp_o, .s_axi_bvalid_o, .s_axi_bready_i,
		.s_axi_araddr_i, .s_axi_arvalid_i, .s_axi_arready_o,
		.s_axi_rdata_o, .s_axi_rresp_o, .s_axi_rvalid_o, .s_axi_rready_i,
		.wr_req_o(wr_req), .wr_ofs_o(wr_ofs), .wr_data_o(wr_data),
		.wr_strb_o(wr_strb), .wr_err_i(wr_err),
		.rd_req_o(rd_req), .rd_ofs_o(rd_ofs), .rd_data_i(rd_data), .rd_err_i(rd_err)
	);

	uart_reg_file uart_reg_file_inst (
		.s_axi_aclk_i, .s_axi_aresetn_i,
		.wr_req_i(wr_req), .wr_ofs_i(wr_ofs), .wr_data_i(wr_data),
		.wr_strb_i(wr_strb), .wr_err_o(wr_err),
		.rd_req_i(rd_req), .rd_ofs_i(rd_ofs), .rd_data_o(rd_data), .rd_err_o(rd_err),
		.tx_push_o(tx_push), .tx_push_data_o(tx_push_data), .tx_pop_o(tx_pop),
		.tx_empty_i(tx_empty), .tx_full_i(tx_full),
		.rx_push_o(rx_push), .rx_pop_o(rx_pop), .rx_head_i(rx_head),
		.rx_empty_i(rx_empty), .rx_full_i(rx_full),
		.tx_en_o, .rx_en_o, .t_done_i, .r_done_i, .baud_div_o
	);

	// host pushes, uart pops
	byte_fifo #(.DEPTH(uart_regs_pkg::FIFO_DEPTH)) tx_fifo (
		.s_axi_aclk_i, .s_axi_aresetn_i,
		.push_i(tx_push), .push_data_i(tx_push_data),
		.pop_i(tx_pop), .pop_data_o(tx_o),
		.empty_o(tx_empty), .full_o(tx_full)
	);

	// uart pushes, host pops
	byte_fifo #(.DEPTH(uart_regs_pkg::FIFO_DEPTH)) rx_fifo (
		.s_axi_aclk_i, .s_axi_aresetn_i,
		.push_i(rx_push), .push_data_i(rx_i),
		.pop_i(rx_pop), .pop_data_o(rx_head),
		.empty_o(rx_empty), .full_o(rx_full)
	);

endmodule

`default_nettype wire

// ==== src/uart_reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_reg_file (
	input  wire                                    s_axi_aclk_i,
	input  wire                                    s_axi_aresetn_i,
	// requests from the bus slave
	input  wire                                    wr_req_i,
	input  wire [uart_regs_pkg::REG_OFS_W-1:0]     wr_ofs_i,
	input  wire [uart_axi_pkg::DATA_W-1:0]         wr_data_i,
	input  wire [uart_axi_pkg::STRB_W-1:0]         wr_strb_i,
	output logic                                   wr_err_o,
	input  wire                                    rd_req_i,
	input  wire [uart_regs_pkg::REG_OFS_W-1:0]     rd_ofs_i,
	output logic [uart_axi_pkg::DATA_W-1:0]        rd_data_o,
	output logic                                   rd_err_o,
	// tx fifo
	output logic                                   tx_push_o,
	output logic [uart_regs_pkg::BYTE_W-1:0]       tx_push_data_o,
	output logic                                   tx_pop_o,
	input  wire                                    tx_empty_i,
	input  wire                                    tx_full_i,
	// rx fifo
	output logic                                   rx_push_o,
	output logic                                   rx_pop_o,
	input  wire [uart_regs_pkg::BYTE_W-1:0]        rx_head_i,
	input  wire                                    rx_empty_i,
	input  wire                                    rx_full_i,
	// uart side
	output logic                                   tx_en_o,
	output logic                                   rx_en_o,
	input  wire                                    t_done_i,
	input  wire                                    r_done_i,
	output logic [uart_regs_pkg::BAUD_W-1:0]       baud_div_o
);

	uart_regs_pkg::ctrl_reg_u ctrl_q;
	logic [3:0] status;
	logic ctrl_we;

	// status is live from the fifo flags
	always_comb begin
		status                             = '0;
		status[uart_regs_pkg::ST_TX_FULL]  = tx_full_i;
		status[uart_regs_pkg::ST_TX_EMPTY] = tx_empty_i;
		status[uart_regs_pkg::ST_RX_FULL]  = rx_full_i;
		status[uart_regs_pkg::ST_RX_EMPTY] = rx_empty_i;
	end

	// write decode
	always_comb begin
		ctrl_we   = 1'b0;
		tx_push_o = 1'b0;
		wr_err_o  = 1'b0;
		case (wr_ofs_i)
			uart_regs_pkg::REG_CTRL: ctrl_we = wr_req_i;
			uart_regs_pkg::REG_WDATA: begin
				if (tx_full_i) begin
					wr_err_o = 1'b1;  // byte dropped, master told
				end else begin
					tx_push_o = wr_req_i;
				end
			end
			default: wr_err_o = 1'b1;  // status, rdata, holes
		endcase
	end

	assign tx_push_data_o = wr_data_i[uart_regs_pkg::BYTE_W-1:0];

	// read decode, side effects only on a real request
	always_comb begin
		rd_data_o = '0;
		rd_err_o  = 1'b0;
		rx_pop_o  = 1'b0;
		case (rd_ofs_i)
			uart_regs_pkg::REG_CTRL: rd_data_o = ctrl_q;
			uart_regs_pkg::REG_STATUS: rd_data_o = {{(uart_axi_pkg::DATA_W-4){1'b0}}, status};
			uart_regs_pkg::REG_RDATA: begin
				if (rx_empty_i) begin
					rd_err_o = 1'b1;
				end else begin
					rd_data_o = {{(uart_axi_pkg::DATA_W-uart_regs_pkg::BYTE_W){1'b0}}, rx_head_i};
					rx_pop_o  = rd_req_i;
				end
			end
			default: rd_err_o = 1'b1;  // wdata is write only
		endcase
	end

	// ctrl, byte lane writes
	always_ff @(posedge s_axi_aclk_i) begin
		if (!s_axi_aresetn_i) begin
			ctrl_q <= '0;
		end else if (ctrl_we) begin
			for (int i = 0; i < uart_axi_pkg::STRB_W; i++) begin
				if (wr_strb_i[i]) begin
					ctrl_q.lane[i] <= wr_data_i[i*uart_regs_pkg::BYTE_W +: uart_regs_pkg::BYTE_W];
				end
			end
		end
	end

	// uart handshake
	assign tx_en_o  = ctrl_q.fld.tx_en && !tx_empty_i;  // something to send
	assign rx_en_o  = ctrl_q.fld.rx_en && !rx_full_i;   // room to receive
	assign tx_pop_o = t_done_i && tx_en_o;
	assign rx_push_o = r_done_i && rx_en_o;

	assign baud_div_o = ctrl_q.fld.baud_div;

endmodule

`default_nettype wire

// ==== src/uart_regs_pkg.sv ====
`default_nettype none

package uart_regs_pkg;

	// register offsets inside the window
	localparam int REG_OFS_W = 4;
	localparam logic [REG_OFS_W-1:0] REG_CTRL   = 4'h0;
	localparam logic [REG_OFS_W-1:0] REG_STATUS = 4'h4;
	localparam logic [REG_OFS_W-1:0] REG_RDATA  = 4'h8;  // read only, pops rx
	localparam logic [REG_OFS_W-1:0] REG_WDATA  = 4'hC;  // write only, pushes tx

	localparam int BYTE_W = 8;
	localparam int BAUD_W = 16;

	localparam int FIFO_DEPTH = 32;

	// status bit positions
	localparam int ST_TX_FULL  = 0;
	localparam int ST_TX_EMPTY = 1;
	localparam int ST_RX_FULL  = 2;
	localparam int ST_RX_EMPTY = 3;

	// both fifos empty, neither full
	localparam logic [3:0] STATUS_RESET = 4'b1010;

	// ctrl word, written per byte lane and read back as fields
	typedef union packed {
		logic [3:0][BYTE_W-1:0] lane;  // lane 0 is bits 7:0
		struct packed {
			logic [BAUD_W-1:0] baud_div;
			logic [13:0]       rsvd;    // kept, reads back as written
			logic              rx_en;
			logic              tx_en;
		} fld;
	} ctrl_reg_u;

endpackage

`default_nettype wire

// ==== testbench/uart_axi_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_axi_props (
	input wire                              s_axi_aclk_i,
	input wire                              s_axi_aresetn_i,
	input wire                              awready_i,
	input wire                              wready_i,
	input wire [1:0]                        bresp_i,
	input wire                              bvalid_i,
	input wire                              bready_i,
	input wire [uart_axi_pkg::DATA_W-1:0]   rdata_i,
	input wire [1:0]                        rresp_i,
	input wire                              rvalid_i,
	input wire                              rready_i
);

	int fail_count = 0;  // read by the testbench at the end

	b_hold: assert property (@(posedge s_axi_aclk_i) disable iff (!s_axi_aresetn_i)
		bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
		else begin
			fail_count++;
			$error("bvalid or bresp changed while waiting for bready");
		end

	r_hold: assert property (@(posedge s_axi_aclk_i) disable iff (!s_axi_aresetn_i)
		rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i) && $stable(rresp_i))
		else begin
			fail_count++;
			$error("rvalid, rdata or rresp changed while waiting for rready");
		end

	// aw and w taken together, response one cycle later
	aw_w_ready: assert property (@(posedge s_axi_aclk_i) disable iff (!s_axi_aresetn_i)
		(awready_i || wready_i) |-> (awready_i && wready_i) ##1 bvalid_i)
		else begin
			fail_count++;
			$error("awready and wready differ or no write response followed");
		end

	rst_valid: assert property (@(posedge s_axi_aclk_i) !s_axi_aresetn_i |=> !bvalid_i && !rvalid_i)
		else begin
			fail_count++;
			$error("response valid high after a reset cycle");
		end

endmodule

bind axi_lite_slave uart_axi_props axi_props_inst (
	.s_axi_aclk_i(s_axi_aclk_i), .s_axi_aresetn_i(s_axi_aresetn_i),
	.awready_i(s_axi_awready_o), .wready_i(s_axi_wready_o),
	.bresp_i(s_axi_bresp_o), .bvalid_i(s_axi_bvalid_o), .bready_i(s_axi_bready_i),
	.rdata_i(s_axi_rdata_o), .rresp_i(s_axi_rresp_o),
	.rvalid_i(s_axi_rvalid_o), .rready_i(s_axi_rready_i)
);

`default_nettype wire

// ==== testbench/uart_axi_tests.svh ====
`ifndef UART_AXI_TESTS_SVH
`define UART_AXI_TESTS_SVH

// expected status word built from the bit map
function automatic logic [31:0] status_word(input logic txf, input logic txe,
		input logic rxf, input logic rxe);
	status_word = '0;
	status_word[uart_regs_pkg::ST_TX_FULL] = txf;
	status_word[uart_regs_pkg::ST_TX_EMPTY] = txe;
	status_word[uart_regs_pkg::ST_RX_FULL] = rxf;
	status_word[uart_regs_pkg::ST_RX_EMPTY] = rxe;
endfunction

task automatic verify_reset_state();
	logic [1:0] resp;
	logic [31:0] data;
	@(negedge aclk);
	check_value("s_axi_awready_o", 0, awready);
	check_value("s_axi_wready_o", 0, wready);
	check_value("s_axi_arready_o", 0, arready);
	check_value("s_axi_bvalid_o", 0, bvalid);
	check_value("s_axi_rvalid_o", 0, rvalid);
	check_value("tx_en_o", 0, tx_en);
	check_value("rx_en_o", 0, rx_en);
	axi_read(reg_addr(uart_regs_pkg::REG_CTRL), resp, data);
	check_value("s_axi_rresp_o", uart_axi_pkg::RESP_OKAY, resp);
	check_value("ctrl", 0, data);
	axi_read(reg_addr(uart_regs_pkg::REG_STATUS), resp, data);
	check_value("s_axi_rresp_o", uart_axi_pkg::RESP_OKAY, resp);
	check_value("status", status_word(0, 1, 0, 1), data);
endtask

task automatic merge_ctrl_strobes();
	logic [1:0] resp;
	logic [31:0] data;
	logic [31:0] wval;
	logic [31:0] exp;
	logic [3:0] strb;
	axi_write(reg_addr(uart_regs_pkg::REG_CTRL), 32'hFFFF_FFFF, 4'hF, resp);
	check_value("s_axi_bresp_o", uart_axi_pkg::RESP_OKAY, resp);
	exp = 32'hFFFF_FFFF;
	wval = $urandom();
	strb = 4'($urandom_range(0, 15));
	axi_write(reg_addr(uart_regs_pkg::REG_CTRL), wval, strb, resp);
	check_value("s_axi_bresp_o", uart_axi_pkg::RESP_OKAY, resp);
	for (int i = 0; i < 4; i++) begin
		if (strb[i]) exp[i*8 +: 8] = wval[i*8 +: 8];  // only strobed lanes change
	end
	axi_read(reg_addr(uart_regs_pkg::REG_CTRL), resp, data);
	check_value("s_axi_rresp_o", uart_axi_pkg::RESP_OKAY, resp);
	check_value("ctrl", exp, data);
	check_value("baud_div_o", exp[31:16], baud_div);
endtask

task automatic drain_tx_fifo();
	logic [1:0] resp;
	logic [31:0] data;
	logic [7:0] sent [$];
	logic [7:0] b;
	uart_regs_pkg::ctrl_reg_u ctrl;
	axi_write(reg_addr(uart_regs_pkg::REG_CTRL), 0, 4'hF, resp);  // tx off while filling
	for (int i = 0; i < uart_regs_pkg::FIFO_DEPTH; i++) begin
		b = 8'($urandom_range(0, 255));
		sent.push_back(b);
		axi_write(reg_addr(uart_regs_pkg::REG_WDATA), {24'h0, b}, 4'hF, resp);
		check_value("s_axi_bresp_o", uart_axi_pkg::RESP_OKAY, resp);
	end
	axi_read(reg_addr(uart_regs_pkg::REG_STATUS), resp, data);
	check_value("status", status_word(1, 0, 0, 1), data);
	axi_write(reg_addr(uart_regs_pkg::REG_WDATA), 32'h5A, 4'hF, resp);
	check_value("s_axi_bresp_o", uart_axi_pkg::RESP_SLVERR, resp);
	tx_log.delete();
	ctrl = '0;
	ctrl.fld.tx_en = 1'b1;
	axi_write(reg_addr(uart_regs_pkg::REG_CTRL), ctrl, 4'hF, resp);
	while (tx_log.size() < uart_regs_pkg::FIFO_DEPTH) @(negedge aclk);
	while (!t_done) @(negedge aclk);  // last pop on the next edge
	@(negedge aclk);
	for (int i = 0; i < uart_regs_pkg::FIFO_DEPTH; i++) begin
		check_value("tx_o", sent[i], tx_log[i]);
	end
	check_value("tx_en_o", 0, tx_en);
	axi_read(reg_addr(uart_regs_pkg::REG_STATUS), resp, data);
	check_value("status", status_word(0, 1, 0, 1), data);
endtask

task automatic fill_rx_fifo();
	logic [1:0] resp;
	logic [31:0] data;
	logic [7:0] exp_q [$];
	uart_regs_pkg::ctrl_reg_u ctrl;
	ctrl = '0;
	ctrl.fld.tx_en = 1'b1;
	ctrl.fld.rx_en = 1'b1;
	axi_write(reg_addr(uart_regs_pkg::REG_CTRL), ctrl, 4'hF, resp);
	for (int i = 0; i < 4; i++) begin
		exp_q.push_back(8'($urandom_range(0, 255)));
		rx_pending.push_back(exp_q[i]);
	end
	while (rx_pending.size() != 0) @(negedge aclk);
	repeat (2) @(negedge aclk);
	for (int i = 0; i < 4; i++) begin
		axi_read(reg_addr(uart_regs_pkg::REG_RDATA), resp, data);
		check_value("s_axi_rresp_o", uart_axi_pkg::RESP_OKAY, resp);
		check_value("s_axi_rdata_o", {24'h0, exp_q[i]}, data);
	end
	axi_read(reg_addr(uart_regs_pkg::REG_RDATA), resp, data);
	check_value("s_axi_rresp_o", uart_axi_pkg::RESP_SLVERR, resp);
	check_value("s_axi_rdata_o", 0, data);
	// one byte more than fits
	for (int i = 0; i <= uart_regs_pkg::FIFO_DEPTH; i++) begin
		rx_pending.push_back(8'($urandom_range(0, 255)));
	end
	do begin
		@(negedge aclk);
	end while (rx_en);
	check_value("bytes left on rx line", 1, rx_pending.size());
	axi_read(reg_addr(uart_regs_pkg::REG_STATUS), resp, data);
	check_value("status", status_word(0, 1, 1, 0), data);
endtask

task automatic reject_bad_access();
	logic [1:0] resp;
	logic [31:0] data;
	logic [31:0] far_addr;
	uart_regs_pkg::ctrl_reg_u ctrl_exp;
	far_addr = uart_axi_pkg::UART_BASE_ADDR + 32'h100;  // ctrl offset, wrong window
	ctrl_exp = '0;  // both enables, as left by the receive test
	ctrl_exp.fld.tx_en = 1'b1;
	ctrl_exp.fld.rx_en = 1'b1;
	axi_write(far_addr, 32'hFFFF_FFFF, 4'hF, resp);
	check_value("s_axi_bresp_o", uart_axi_pkg::RESP_SLVERR, resp);
	axi_write(reg_addr(uart_regs_pkg::REG_STATUS), 32'hFFFF_FFFF, 4'hF, resp);
	check_value("s_axi_bresp_o", uart_axi_pkg::RESP_SLVERR, resp);
	axi_read(reg_addr(uart_regs_pkg::REG_WDATA), resp, data);
	check_value("s_axi_rresp_o", uart_axi_pkg::RESP_SLVERR, resp);
	check_value("s_axi_rdata_o", 0, data);
	axi_read(far_addr, resp, data);
	check_value("s_axi_rresp_o", uart_axi_pkg::RESP_SLVERR, resp);
	axi_read(reg_addr(uart_regs_pkg::REG_CTRL), resp, data);
	check_value("ctrl", ctrl_exp, data);
	axi_read(reg_addr(uart_regs_pkg::REG_STATUS), resp, data);
	check_value("status", status_word(0, 1, 1, 0), data);
endtask

task automatic hold_responses();
	logic [1:0] resp;
	logic [31:0] data;
	logic [31:0] w1;
	logic [31:0] w2;
	int hold;
	w1 = $urandom();
	w2 = $urandom();
	hold = $urandom_range(2, 8);
	send_write(reg_addr(uart_regs_pkg::REG_CTRL), w1, 4'hF);
	@(posedge aclk);
	wdata <= w2;
	awvalid <= 1'b1;
	wvalid <= 1'b1;
	repeat (hold) begin
		@(negedge aclk);
		if (awready) report_error("second write accepted while bvalid was held");
	end
	take_write_resp(0, resp);
	check_value("s_axi_bresp_o", uart_axi_pkg::RESP_OKAY, resp);
	wait_write_accept();
	take_write_resp(hold, resp);
	check_value("s_axi_bresp_o", uart_axi_pkg::RESP_OKAY, resp);
	send_read(reg_addr(uart_regs_pkg::REG_STATUS));
	@(posedge aclk);
	araddr <= reg_addr(uart_regs_pkg::REG_CTRL);
	arvalid <= 1'b1;
	repeat (hold) begin
		@(negedge aclk);
		if (arready) report_error("second read accepted while rvalid was held");
	end
	take_read_resp(0, resp, data);
	check_value("s_axi_rresp_o", uart_axi_pkg::RESP_OKAY, resp);
	check_value("status", status_word(0, 1, 1, 0), data);
	wait_read_accept();
	take_read_resp(hold, resp, data);
	check_value("s_axi_rresp_o", uart_axi_pkg::RESP_OKAY, resp);
	check_value("ctrl", w2, data);
endtask

`endif

// ==== testbench/uart_axi_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_axi_tb;

	localparam int MAX_CYCLES = 6000;  // tests need under 2000 cycles

	logic aclk;
	logic aresetn;
	logic [uart_axi_pkg::ADDR_W-1:0] awaddr;
	logic [uart_axi_pkg::ADDR_W-1:0] araddr;
	logic [uart_axi_pkg::DATA_W-1:0] wdata;
	logic [uart_axi_pkg::DATA_W-1:0] rdata;
	logic [uart_axi_pkg::STRB_W-1:0] wstrb;
	logic [1:0] bresp;
	logic [1:0] rresp;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	logic [uart_regs_pkg::BYTE_W-1:0] tx_byte;
	logic [uart_regs_pkg::BYTE_W-1:0] rx_byte;
	logic [uart_regs_pkg::BAUD_W-1:0] baud_div;
	logic tx_en, t_done, rx_en, r_done;

	int errors = 0;
	int checks = 0;
	int cycles = 0;
	logic [uart_regs_pkg::BYTE_W-1:0] tx_log [$];      // bytes taken by the line model
	logic [uart_regs_pkg::BYTE_W-1:0] rx_pending [$];  // bytes still to be received

	uart_axi_top uart_axi_top_inst (
		.s_axi_aclk_i(aclk), .s_axi_aresetn_i(aresetn),
		.s_axi_awaddr_i(awaddr), .s_axi_awvalid_i(awvalid), .s_axi_awready_o(awready),
		.s_axi_wdata_i(wdata), .s_axi_wstrb_i(wstrb), .s_axi_wvalid_i(wvalid),
		.s_axi_wready_o(wready),
		.s_axi_bresp_o(bresp), .s_axi_bvalid_o(bvalid), .s_axi_bready_i(bready),
		.s_axi_araddr_i(araddr), .s_axi_arvalid_i(arvalid), .s_axi_arready_o(arready),
		.s_axi_rdata_o(rdata), .s_axi_rresp_o(rresp), .s_axi_rvalid_o(rvalid),
		.s_axi_rready_i(rready),
		.tx_o(tx_byte), .tx_en_o(tx_en), .t_done_i(t_done),
		.rx_i(rx_byte), .rx_en_o(rx_en), .r_done_i(r_done), .baud_div_o(baud_div)
	);

	initial begin
		aclk = 1'b0;
		forever #20 aclk = ~aclk;
	end

	always @(posedge aclk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout after %0d cycles, a handshake never completed", cycles);
			$display("test failed");
			$finish;
		end
	end

	// tx line, takes the head byte a few cycles after tx_en_o
	initial begin
		int gap;
		t_done <= 1'b0;
		forever begin
			@(negedge aclk);
			if (tx_en) begin
				tx_log.push_back(tx_byte);
				gap = $urandom_range(1, 3);
				repeat (gap) @(posedge aclk);
				t_done <= 1'b1;
				@(posedge aclk);
				t_done <= 1'b0;
			end
		end
	end

	// rx line, one byte per r_done_i pulse
	initial begin
		r_done <= 1'b0;
		rx_byte <= '0;
		forever begin
			@(negedge aclk);
			if (rx_en && rx_pending.size() > 0) begin
				@(posedge aclk);
				rx_byte <= rx_pending.pop_front();
				r_done <= 1'b1;
				@(posedge aclk);
				r_done <= 1'b0;
			end
		end
	end

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAIL at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic report_error(input string what);
		errors++;
		$display("ERROR at %0t ns: %s", $time, what);
	endtask

	function automatic logic [31:0] reg_addr(input logic [uart_regs_pkg::REG_OFS_W-1:0] ofs);
		return uart_axi_pkg::UART_BASE_ADDR | {28'h0, ofs};
	endfunction

	task automatic wait_write_accept();
		do begin
			@(negedge aclk);
		end while (!awready);
		check_value("s_axi_wready_o", 1, wready);
		@(posedge aclk);  // transfer edge
		awvalid <= 1'b0;
		wvalid <= 1'b0;
	endtask

	task automatic send_write(input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] strb);
		@(posedge aclk);
		awaddr <= addr;
		wdata <= data;
		wstrb <= strb;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		wait_write_accept();
	endtask

	task automatic take_write_resp(input int hold, output logic [1:0] resp);
		@(negedge aclk);
		if (!bvalid) report_error("no write response one cycle after accept");
		repeat (hold) @(negedge aclk);
		@(posedge aclk);
		bready <= 1'b1;
		@(negedge aclk);
		resp = bresp;  // value at the handshake
		@(posedge aclk);
		bready <= 1'b0;
	endtask

	task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] strb, output logic [1:0] resp);
		send_write(addr, data, strb);
		take_write_resp(0, resp);
	endtask

	task automatic wait_read_accept();
		do begin
			@(negedge aclk);
		end while (!arready);
		@(posedge aclk);
		arvalid <= 1'b0;
	endtask

	task automatic send_read(input logic [31:0] addr);
		@(posedge aclk);
		araddr <= addr;
		arvalid <= 1'b1;
		wait_read_accept();
	endtask

	task automatic take_read_resp(input int hold, output logic [1:0] resp,
			output logic [31:0] data);
		@(negedge aclk);
		if (!rvalid) report_error("no read data one cycle after accept");
		repeat (hold) @(negedge aclk);
		@(posedge aclk);
		rready <= 1'b1;
		@(negedge aclk);
		resp = rresp;
		data = rdata;
		@(posedge aclk);
		rready <= 1'b0;
	endtask

	task automatic axi_read(input logic [31:0] addr, output logic [1:0] resp,
			output logic [31:0] data);
		send_read(addr);
		take_read_resp(0, resp, data);
	endtask

	`include "uart_axi_tests.svh"

	initial begin
		int seed_ret;
		int assert_fails;
		seed_ret = $urandom(32'h964e);
		aresetn <= 1'b0;
		awaddr <= '0;
		awvalid <= 1'b0;
		wdata <= '0;
		wstrb <= '0;
		wvalid <= 1'b0;
		bready <= 1'b0;
		araddr <= '0;
		arvalid <= 1'b0;
		rready <= 1'b0;
		repeat (3) @(posedge aclk);
		aresetn <= 1'b1;
		verify_reset_state();
		merge_ctrl_strobes();
		drain_tx_fifo();
		fill_rx_fifo();
		reject_bad_access();
		hold_responses();
		assert_fails = uart_axi_top_inst.axi_lite_slave_inst.axi_props_inst.fail_count;
		$display("%0d checks, %0d errors, %0d assertion failures", checks, errors, assert_fails);
		if (errors == 0 && assert_fails == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
